// File: rtl/uart_cfg_pkg.sv
package uart_cfg_pkg;

   // serial line format, 8N1 at 115200 baud from 50 MHz
   localparam int unsigned bit_period  = 434;
   localparam int unsigned half_period = 217; // start edge to mid start bit

   localparam int unsigned fifo_depth  = 64;

   typedef logic [7:0] byte_t;
   typedef logic [5:0] fifo_ptr_t;  // wraps at fifo_depth
   typedef logic [8:0] baud_cnt_t;
   typedef logic [3:0] bit_idx_t;

   typedef enum logic [1:0] {
      tx_idle,
      tx_start,
      tx_data,
      tx_stop
   } tx_state_t;

   typedef enum logic [1:0] {
      rx_idle,
      rx_start,
      rx_data,
      rx_stop
   } rx_state_t;

   // one received frame as handed to the register block
   typedef struct packed {
      logic  valid;     // single-cycle strobe
      byte_t data;
      logic  frame_err; // stop bit read low
   } rx_byte_t;

endpackage

// File: rtl/uart_bus_pkg.sv
package uart_bus_pkg;

   typedef logic [1:0] wb_addr_t; // word address

   typedef struct packed {
      logic                cyc;
      logic                stb;
      logic                we;
      wb_addr_t            adr;
      uart_cfg_pkg::byte_t dat;
   } wb_req_t;

   typedef struct packed {
      logic                ack;
      uart_cfg_pkg::byte_t dat;
   } wb_rsp_t;

   // register map
   localparam wb_addr_t addr_data   = 2'd0; // wr queues tx byte, rd pops rx byte
   localparam wb_addr_t addr_status = 2'd1; // read only
   localparam wb_addr_t addr_ctrl   = 2'd2; // bit 0 clears sticky errors

   // status byte layout
   localparam int unsigned st_rx_valid   = 0;
   localparam int unsigned st_tx_empty   = 1;
   localparam int unsigned st_tx_full    = 2;
   localparam int unsigned st_of_err     = 3;
   localparam int unsigned st_rx_overrun = 4;
   localparam int unsigned st_frame_err  = 5;

endpackage

// File: rtl/tx_fifo.sv
module tx_fifo (
   input  logic                clk,
   input  logic                rst,
   input  logic                push,
   input  uart_cfg_pkg::byte_t push_data,
   input  logic                pop,
   output uart_cfg_pkg::byte_t head_data,
   output logic                empty,
   output logic                full,
   output logic                of_err,
   input  logic                clr_err
);

   uart_cfg_pkg::byte_t     mem [uart_cfg_pkg::fifo_depth];
   uart_cfg_pkg::fifo_ptr_t head;
   uart_cfg_pkg::fifo_ptr_t tail;
   uart_cfg_pkg::fifo_ptr_t tail_nxt;
   logic                    wr_en;

   assign tail_nxt  = tail + 1'b1;
   assign empty     = (head == tail);
   assign full      = (tail_nxt == head); // one slot always left unused
   assign wr_en     = push & (~full | pop);
   assign head_data = mem[head];

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[tail] <= push_data;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         head <= '0;
         tail <= '0;
      end else begin
         if (pop) begin
            head <= head + 1'b1;
         end
         if (wr_en) begin
            tail <= tail_nxt;
         end
      end
   end

   // sticky until software clears it
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         of_err <= 1'b0;
      end else if (push && full && !pop) begin
         of_err <= 1'b1;
      end else if (clr_err) begin
         of_err <= 1'b0;
      end
   end

   // the transmitter must only pop when a byte is waiting
   a_no_pop_empty : assert property (@(posedge clk) disable iff (rst) pop |-> !empty);

endmodule

// File: rtl/uart_tx.sv
module uart_tx (
   input  logic                clk,
   input  logic                rst,
   input  uart_cfg_pkg::byte_t head_data,
   input  logic                empty,
   output logic                pop,
   output logic                txd
);

   uart_cfg_pkg::baud_cnt_t baud_cnt;
   uart_cfg_pkg::tx_state_t state;
   uart_cfg_pkg::bit_idx_t  bit_idx;
   uart_cfg_pkg::byte_t     shreg;
   logic                    tick;
   logic                    can_start;

   // free-running bit clock, never restarted
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         baud_cnt <= '0;
      end else if (tick) begin
         baud_cnt <= '0;
      end else begin
         baud_cnt <= baud_cnt + 1'b1;
      end
   end

   assign tick = (baud_cnt == uart_cfg_pkg::baud_cnt_t'(uart_cfg_pkg::bit_period - 1));

   // a new frame may follow the stop bit directly
   assign can_start = (state == uart_cfg_pkg::tx_idle) || (state == uart_cfg_pkg::tx_stop);
   assign pop       = tick & can_start & ~empty;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state   <= uart_cfg_pkg::tx_idle;
         txd     <= 1'b1;
         bit_idx <= '0;
      end else if (tick) begin
         case (state)
            uart_cfg_pkg::tx_idle,
            uart_cfg_pkg::tx_stop: begin
               if (pop) begin
                  state <= uart_cfg_pkg::tx_start;
                  txd   <= 1'b0; // start bit
               end else begin
                  state <= uart_cfg_pkg::tx_idle;
                  txd   <= 1'b1;
               end
            end
            uart_cfg_pkg::tx_start: begin
               state   <= uart_cfg_pkg::tx_data;
               txd     <= shreg[0];
               bit_idx <= '0;
            end
            uart_cfg_pkg::tx_data: begin
               if (bit_idx == uart_cfg_pkg::bit_idx_t'(7)) begin
                  state <= uart_cfg_pkg::tx_stop;
                  txd   <= 1'b1; // stop bit
               end else begin
                  txd     <= shreg[0];
                  bit_idx <= bit_idx + 1'b1;
               end
            end
            default: begin
               state <= uart_cfg_pkg::tx_idle;
               txd   <= 1'b1;
            end
         endcase
      end
   end

   // lsb first
   always_ff @(posedge clk) begin
      if (pop) begin
         shreg <= head_data;
      end else if (tick && (state == uart_cfg_pkg::tx_start ||
                            state == uart_cfg_pkg::tx_data)) begin
         shreg <= shreg >> 1;
      end
   end

   a_idle_high : assert property (@(posedge clk) disable iff (rst)
      state == uart_cfg_pkg::tx_idle |-> txd);

   // a pop on a tick opens a start bit that spans a whole bit period
   a_pop_on_tick : assert property (@(posedge clk) disable iff (rst)
      pop |=> !txd ##(uart_cfg_pkg::bit_period - 1) !txd);

endmodule

// File: rtl/uart_rx.sv
module uart_rx (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   rxd,
   output uart_cfg_pkg::rx_byte_t rx_out
);

   logic                    rxd_s1;
   logic                    rxd_s2;
   logic                    rxd_q;
   logic                    fall;
   logic                    half_done;
   logic                    bit_done;
   uart_cfg_pkg::rx_state_t state;
   uart_cfg_pkg::baud_cnt_t cnt;
   uart_cfg_pkg::bit_idx_t  bit_idx;
   uart_cfg_pkg::byte_t     shreg;
   uart_cfg_pkg::byte_t     data_q;
   logic                    ferr_q;
   logic                    valid_q;

   // two-flop synchronizer plus edge history, line idles high
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         rxd_s1 <= 1'b1;
         rxd_s2 <= 1'b1;
         rxd_q  <= 1'b1;
      end else begin
         rxd_s1 <= rxd;
         rxd_s2 <= rxd_s1;
         rxd_q  <= rxd_s2;
      end
   end

   assign fall      = rxd_q & ~rxd_s2;
   assign half_done = (cnt == uart_cfg_pkg::baud_cnt_t'(uart_cfg_pkg::half_period - 1));
   assign bit_done  = (cnt == uart_cfg_pkg::baud_cnt_t'(uart_cfg_pkg::bit_period - 1));

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state   <= uart_cfg_pkg::rx_idle;
         cnt     <= '0;
         bit_idx <= '0;
         valid_q <= 1'b0;
      end else begin
         valid_q <= 1'b0;
         case (state)
            uart_cfg_pkg::rx_idle: begin
               if (fall) begin
                  state <= uart_cfg_pkg::rx_start;
                  cnt   <= '0;
               end
            end
            uart_cfg_pkg::rx_start: begin
               if (half_done) begin
                  cnt     <= '0;
                  bit_idx <= '0;
                  // glitch, not a real start bit
                  state   <= rxd_s2 ? uart_cfg_pkg::rx_idle : uart_cfg_pkg::rx_data;
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            uart_cfg_pkg::rx_data: begin
               if (bit_done) begin
                  cnt <= '0;
                  if (bit_idx == uart_cfg_pkg::bit_idx_t'(7)) begin
                     state <= uart_cfg_pkg::rx_stop;
                  end else begin
                     bit_idx <= bit_idx + 1'b1;
                  end
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            default: begin // stop bit
               if (bit_done) begin
                  valid_q <= 1'b1;
                  state   <= uart_cfg_pkg::rx_idle;
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == uart_cfg_pkg::rx_data && bit_done) begin
         shreg <= {rxd_s2, shreg[7:1]}; // lsb arrives first
      end
      if (state == uart_cfg_pkg::rx_stop && bit_done) begin
         data_q <= shreg;
         ferr_q <= ~rxd_s2;
      end
   end

   assign rx_out = '{valid: valid_q, data: data_q, frame_err: ferr_q};

   a_valid_pulse : assert property (@(posedge clk) disable iff (rst)
      rx_out.valid |=> !rx_out.valid);

endmodule

// File: rtl/uart_wb_regs.sv
module uart_wb_regs (
   input  logic                   clk,
   input  logic                   rst,
   input  uart_bus_pkg::wb_req_t  wb_i,
   output uart_bus_pkg::wb_rsp_t  wb_o,
   output logic                   push,
   output uart_cfg_pkg::byte_t    push_data,
   input  logic                   tx_empty,
   input  logic                   tx_full,
   input  logic                   of_err,
   input  uart_cfg_pkg::rx_byte_t rx_in,
   output logic                   clr_err
);

   logic                req;
   logic                req_seen;
   logic                ack_q;
   logic                wr;
   logic                rd;
   logic                rd_data;
   logic                hold_valid;
   logic                rx_overrun;
   logic                frame_err;
   uart_cfg_pkg::byte_t hold_data;
   uart_cfg_pkg::byte_t status;
   uart_cfg_pkg::byte_t rd_mux;
   uart_cfg_pkg::byte_t dat_q;

   assign req = wb_i.cyc & wb_i.stb;
   assign wr  = req & ~req_seen & wb_i.we;  // lands on the ack edge
   assign rd  = req & ~req_seen & ~wb_i.we;

   assign push      = wr & (wb_i.adr == uart_bus_pkg::addr_data);
   assign push_data = wb_i.dat;
   assign clr_err   = wr & (wb_i.adr == uart_bus_pkg::addr_ctrl) & wb_i.dat[0];
   assign rd_data   = rd & (wb_i.adr == uart_bus_pkg::addr_data);

   // one ack per strobe, rearmed once stb drops
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         req_seen <= 1'b0;
         ack_q    <= 1'b0;
      end else begin
         req_seen <= wb_i.stb & (req_seen | wb_i.cyc);
         ack_q    <= req & ~req_seen;
      end
   end

   // rx holding register, a read in the same cycle makes room
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         hold_valid <= 1'b0;
         hold_data  <= '0;
      end else if (rx_in.valid && (!hold_valid || rd_data)) begin
         hold_valid <= 1'b1;
         hold_data  <= rx_in.data;
      end else if (rd_data) begin
         hold_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         rx_overrun <= 1'b0;
         frame_err  <= 1'b0;
      end else begin
         if (rx_in.valid && hold_valid && !rd_data) begin
            rx_overrun <= 1'b1; // new byte dropped
         end else if (clr_err) begin
            rx_overrun <= 1'b0;
         end
         if (rx_in.valid && rx_in.frame_err) begin
            frame_err <= 1'b1;
         end else if (clr_err) begin
            frame_err <= 1'b0;
         end
      end
   end

   always_comb begin
      status = '0;
      status[uart_bus_pkg::st_rx_valid]   = hold_valid;
      status[uart_bus_pkg::st_tx_empty]   = tx_empty;
      status[uart_bus_pkg::st_tx_full]    = tx_full;
      status[uart_bus_pkg::st_of_err]     = of_err;
      status[uart_bus_pkg::st_rx_overrun] = rx_overrun;
      status[uart_bus_pkg::st_frame_err]  = frame_err;
   end

   always_comb begin
      case (wb_i.adr)
         uart_bus_pkg::addr_data:   rd_mux = hold_data;
         uart_bus_pkg::addr_status: rd_mux = status;
         default:                   rd_mux = '0; // ctrl is write only
      endcase
   end

   always_ff @(posedge clk) begin
      if (rd) begin
         dat_q <= rd_mux;
      end
   end

   assign wb_o = '{ack: ack_q, dat: dat_q};

   a_ack_single : assert property (@(posedge clk) disable iff (rst)
      wb_o.ack |=> !wb_o.ack);

endmodule

// File: rtl/uart_top.sv
module uart_top (
   input  logic                  clk,
   input  logic                  rst,
   input  uart_bus_pkg::wb_req_t wb_i,
   output uart_bus_pkg::wb_rsp_t wb_o,
   output logic                  txd,
   input  logic                  rxd
);

   logic                   push;
   logic                   pop;
   logic                   tx_empty;
   logic                   tx_full;
   logic                   of_err;
   logic                   clr_err;
   uart_cfg_pkg::byte_t    push_data;
   uart_cfg_pkg::byte_t    head_data;
   uart_cfg_pkg::rx_byte_t rx_byte;

   uart_wb_regs u_regs (
      .clk       (clk),
      .rst       (rst),
      .wb_i      (wb_i),
      .wb_o      (wb_o),
      .push      (push),
      .push_data (push_data),
      .tx_empty  (tx_empty),
      .tx_full   (tx_full),
      .of_err    (of_err),
      .rx_in     (rx_byte),
      .clr_err   (clr_err)
   );

   tx_fifo u_fifo (
      .clk       (clk),
      .rst       (rst),
      .push      (push),
      .push_data (push_data),
      .pop       (pop),
      .head_data (head_data),
      .empty     (tx_empty),
      .full      (tx_full),
      .of_err    (of_err),
      .clr_err   (clr_err)
   );

   uart_tx u_tx (
      .clk       (clk),
      .rst       (rst),
      .head_data (head_data),
      .empty     (tx_empty),
      .pop       (pop),
      .txd       (txd)
   );

   uart_rx u_rx (
      .clk    (clk),
      .rst    (rst),
      .rxd    (rxd),
      .rx_out (rx_byte)
   );

endmodule

// File: dv/uart_tb.sv
module uart_tb;

   timeunit 1ns;
   timeprecision 1ps;

   // about 230 ten-bit frames plus margin
   localparam int unsigned timeout_cycles = 230 * 10 * uart_cfg_pkg::bit_period + 200_000;

   logic                  clk;
   logic                  rst;
   logic                  rxd;
   logic                  txd;
   logic                  loop_sel; // 1: rxd follows txd
   logic                  enc_line;
   uart_bus_pkg::wb_req_t wb_i;
   uart_bus_pkg::wb_rsp_t wb_o;

   uart_cfg_pkg::byte_t tx_seen[$]; // bytes decoded from txd
   uart_cfg_pkg::byte_t exp_tx[$];

   // expected rx register and sticky bits
   logic                exp_rx_valid;
   uart_cfg_pkg::byte_t exp_rx_data;
   logic                exp_of_err;
   logic                exp_overrun;
   logic                exp_frame_err;

   uart_top DUT (
      .clk  (clk),
      .rst  (rst),
      .wb_i (wb_i),
      .wb_o (wb_o),
      .txd  (txd),
      .rxd  (rxd)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   always @(negedge clk) begin
      rxd <= loop_sel ? txd : enc_line;
   end

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Checks failed");
      $fatal(1);
   endtask

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         fail_run($sformatf("Error: %s is 0x%0h, expected 0x%0h", name, got, exp));
      end
   endtask

   initial begin : watchdog
      int unsigned cycles;
      cycles = 0;
      while (cycles < timeout_cycles) begin
         @(posedge clk);
         cycles++;
      end
      fail_run("simulation ran past the cycle limit without finishing");
   end

   // decode txd, each bit must hold its value for a whole bit period
   initial begin : txd_monitor
      uart_cfg_pkg::byte_t shift;
      logic                edge_val;
      logic                mid_val;
      int                  i;
      @(negedge rst);
      forever begin
         @(negedge txd);
         for (i = 0; i < 10; i++) begin
            @(negedge clk);
            edge_val = txd;
            repeat (uart_cfg_pkg::half_period - 1) @(negedge clk);
            mid_val = txd;
            repeat (uart_cfg_pkg::bit_period - uart_cfg_pkg::half_period) @(negedge clk);
            if (txd !== edge_val || mid_val !== edge_val) begin
               fail_run($sformatf("txd changed inside bit %0d of a frame", i));
            end
            if (i == 0) begin
               check("txd start bit", mid_val, 1'b0);
            end else if (i == 9) begin
               check("txd stop bit", mid_val, 1'b1);
            end else begin
               shift[i-1] = mid_val; // lsb first
            end
         end
         tx_seen.push_back(shift);
      end
   end

   task automatic bus_cycle(input logic we, input uart_bus_pkg::wb_addr_t adr,
                            input uart_cfg_pkg::byte_t dat, output uart_cfg_pkg::byte_t rdat);
      int n;
      n = 0;
      @(negedge clk);
      wb_i.cyc = 1'b1;
      wb_i.stb = 1'b1;
      wb_i.we  = we;
      wb_i.adr = adr;
      wb_i.dat = dat;
      do begin
         @(negedge clk);
         n++;
      end while (!wb_o.ack && n < 16);
      if (!wb_o.ack) begin
         fail_run("no Wishbone ack within 16 cycles");
      end
      rdat = wb_o.dat;
      wb_i = '0;
   endtask

   task automatic wb_write(input uart_bus_pkg::wb_addr_t adr, input uart_cfg_pkg::byte_t dat);
      uart_cfg_pkg::byte_t unused;
      bus_cycle(1'b1, adr, dat, unused);
   endtask

   task automatic wb_read(input uart_bus_pkg::wb_addr_t adr, output uart_cfg_pkg::byte_t dat);
      bus_cycle(1'b0, adr, 8'h00, dat);
   endtask

   // serial frame on the testbench line, stop bit value selectable
   task automatic send_byte(input uart_cfg_pkg::byte_t b, input logic stop_bit);
      logic [9:0] frame;
      int         i;
      frame = {stop_bit, b, 1'b0};
      for (i = 0; i < 10; i++) begin
         enc_line <= frame[i];
         repeat (uart_cfg_pkg::bit_period) @(negedge clk);
      end
      enc_line <= 1'b1;
      repeat (20) @(negedge clk);
   endtask

   function automatic uart_cfg_pkg::byte_t status_word(input logic rx_valid, input logic tx_empty,
                                                       input logic tx_full, input logic of_err,
                                                       input logic overrun, input logic frame_err);
      uart_cfg_pkg::byte_t st;
      st = '0;
      st[uart_bus_pkg::st_rx_valid]   = rx_valid;
      st[uart_bus_pkg::st_tx_empty]   = tx_empty;
      st[uart_bus_pkg::st_tx_full]    = tx_full;
      st[uart_bus_pkg::st_of_err]     = of_err;
      st[uart_bus_pkg::st_rx_overrun] = overrun;
      st[uart_bus_pkg::st_frame_err]  = frame_err;
      return st;
   endfunction

   // a frame arriving at the receiver
   task automatic model_rx(input uart_cfg_pkg::byte_t b, input logic stop_bit);
      if (exp_rx_valid) begin
         exp_overrun = 1'b1;
      end else begin
         exp_rx_valid = 1'b1;
         exp_rx_data  = b;
      end
      if (!stop_bit) begin
         exp_frame_err = 1'b1;
      end
   endtask

   task automatic read_and_check_data();
      uart_cfg_pkg::byte_t d;
      wb_read(uart_bus_pkg::addr_data, d);
      check("rx data", d, exp_rx_data);
      exp_rx_valid = 1'b0;
   endtask

   task automatic check_status_idle_tx();
      uart_cfg_pkg::byte_t st;
      wb_read(uart_bus_pkg::addr_status, st);
      check("status", st, status_word(exp_rx_valid, 1'b1, 1'b0, exp_of_err, exp_overrun,
                                      exp_frame_err));
   endtask

   task automatic clear_errors();
      wb_write(uart_bus_pkg::addr_ctrl, 8'h01);
      exp_of_err    = 1'b0;
      exp_overrun   = 1'b0;
      exp_frame_err = 1'b0;
   endtask

   task automatic wait_tx_count(input int n);
      while (tx_seen.size() < n) @(negedge clk);
   endtask

   initial begin : main
      uart_cfg_pkg::byte_t b;
      uart_cfg_pkg::byte_t c;
      uart_cfg_pkg::byte_t st;
      uart_cfg_pkg::byte_t sent[$];
      int                  i;
      void'($urandom(32'h8bf8_cdf8));
      rst           = 1'b1;
      rxd           = 1'b1;
      enc_line      = 1'b1;
      loop_sel      = 1'b0;
      wb_i          = '0;
      exp_rx_valid  = 1'b0;
      exp_rx_data   = '0;
      exp_of_err    = 1'b0;
      exp_overrun   = 1'b0;
      exp_frame_err = 1'b0;
      repeat (4) @(negedge clk);
      rst = 1'b0;

      // reset state
      check("txd", txd, 1'b1);
      check_status_idle_tx();
      read_and_check_data();

      // transmit order and frame format
      for (i = 0; i < 20; i++) begin
         b = uart_cfg_pkg::byte_t'($urandom);
         exp_tx.push_back(b);
         wb_write(uart_bus_pkg::addr_data, b);
         repeat ($urandom % 3001) @(negedge clk);
      end
      wait_tx_count(20);
      repeat (11 * uart_cfg_pkg::bit_period) @(negedge clk);
      check("tx byte count", tx_seen.size(), 20);
      for (i = 0; i < 20; i++) begin
         check("txd byte", tx_seen[i], exp_tx.pop_front());
      end

      // loopback receive
      loop_sel = 1'b1;
      for (i = 0; i < 20; i++) begin
         b = uart_cfg_pkg::byte_t'($urandom);
         wb_write(uart_bus_pkg::addr_data, b);
         model_rx(b, 1'b1);
         do wb_read(uart_bus_pkg::addr_status, st); while (!st[uart_bus_pkg::st_rx_valid]);
         read_and_check_data();
         wb_read(uart_bus_pkg::addr_status, st);
         check("status rx_valid", st[uart_bus_pkg::st_rx_valid], 1'b0);
      end
      loop_sel = 1'b0;

      // transmit overflow, 70 writes well inside one bit period
      repeat (uart_cfg_pkg::bit_period) @(negedge clk); // last monitor frame ends
      tx_seen.delete();
      for (i = 0; i < 70; i++) begin
         b = uart_cfg_pkg::byte_t'($urandom);
         sent.push_back(b);
         wb_write(uart_bus_pkg::addr_data, b);
      end
      exp_of_err = 1'b1;
      wb_read(uart_bus_pkg::addr_status, st);
      check("status of_err", st[uart_bus_pkg::st_of_err], 1'b1);
      do wb_read(uart_bus_pkg::addr_status, st); while (!st[uart_bus_pkg::st_tx_empty]);
      wait_tx_count(63);
      repeat (11 * uart_cfg_pkg::bit_period) @(negedge clk);
      if (tx_seen.size() != 63 && tx_seen.size() != 64) begin
         fail_run($sformatf("transmitter sent %0d bytes after overflow, expected 63 or 64",
                            tx_seen.size()));
      end
      for (i = 0; i < tx_seen.size(); i++) begin
         check("txd byte after overflow", tx_seen[i], sent[i]);
      end
      clear_errors();
      check_status_idle_tx();

      // receive overrun
      b = uart_cfg_pkg::byte_t'($urandom);
      c = uart_cfg_pkg::byte_t'($urandom);
      send_byte(b, 1'b1);
      model_rx(b, 1'b1);
      send_byte(c, 1'b1);
      model_rx(c, 1'b1);
      check_status_idle_tx();
      read_and_check_data();
      check_status_idle_tx();
      clear_errors();
      check_status_idle_tx();

      // frame error, stop bit driven low
      b = uart_cfg_pkg::byte_t'($urandom);
      send_byte(b, 1'b0);
      model_rx(b, 1'b0);
      check_status_idle_tx();
      read_and_check_data();
      clear_errors();
      wb_read(uart_bus_pkg::addr_status, st);
      check("status after clear", st, 8'h02);

      $display("All checks passed");
      $finish;
   end

endmodule

// File: project.f
rtl/uart_cfg_pkg.sv
rtl/uart_bus_pkg.sv
rtl/tx_fifo.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/uart_wb_regs.sv
rtl/uart_top.sv
dv/uart_tb.sv

// File: Bender.yml
package:
  name: uart_wb

sources:
  - rtl/uart_cfg_pkg.sv
  - rtl/uart_bus_pkg.sv
  - rtl/tx_fifo.sv
  - rtl/uart_tx.sv
  - rtl/uart_rx.sv
  - rtl/uart_wb_regs.sv
  - rtl/uart_top.sv
  - target: test
    files:
      - dv/uart_tb.sv
